//--- design/mem_pkg.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared memory subsystem package
// sizes, address map, enums and bus structs for the scratchpad
// ~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package mem_pkg;

  // word and memory sizes
  localparam int DATA_W     = 32;
  localparam int STRB_W     = DATA_W / 8;
  localparam int MEM_WORDS  = 256;
  localparam int MEM_ADDR_W = 8;
  localparam int AXI_ADDR_W = 12;

  // byte address map: [11:10] region, [9:2] word, [1:0] ignored
  localparam int WORD_LSB   = 2;
  localparam int REGION_LSB = 10;
  localparam int REGION_W   = 2;

  // region decode, every region aliases the same words
  typedef enum logic [1:0] {
    MEM_OP_WRITE = 2'd0,
    MEM_OP_SET   = 2'd1,
    MEM_OP_CLEAR = 2'd2,
    MEM_OP_BAD   = 2'd3
  } mem_op_e;

  typedef enum logic [1:0] {
    RESP_OKAY   = 2'd0,
    RESP_SLVERR = 2'd2
  } axi_resp_e;

  typedef enum logic [1:0] {
    PORT_IDLE,
    PORT_WAIT_GRANT,
    PORT_READ_DATA,
    PORT_RESP
  } port_state_e;

  // one access to the 1rw memory
  typedef struct packed {
    logic                  valid;
    logic                  we;
    logic [MEM_ADDR_W-1:0] addr;
    logic [DATA_W-1:0]     wdata;
    logic [DATA_W-1:0]     wmask;
  } mem_req_t;

  // master to slave
  typedef struct packed {
    logic                  awvalid;
    logic [AXI_ADDR_W-1:0] awaddr;
    logic                  wvalid;
    logic [DATA_W-1:0]     wdata;
    logic [STRB_W-1:0]     wstrb;
    logic                  bready;
    logic                  arvalid;
    logic [AXI_ADDR_W-1:0] araddr;
    logic                  rready;
  } axil_req_t;

  // slave to master
  typedef struct packed {
    logic              awready;
    logic              wready;
    logic              bvalid;
    axi_resp_e         bresp;
    logic              arready;
    logic              rvalid;
    logic [DATA_W-1:0] rdata;
    axi_resp_e         rresp;
  } axil_rsp_t;

endpackage

`default_nettype wire

//--- design/mem_1rw_sync_mask_write_bit.sv
// ~~~~~~~~~~~~~~~~~~~~
// single-port synchronous RAM
// one read or one bit-masked write per cycle, registered read data
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_1rw_sync_mask_write_bit (
  input  logic                       clk_i,
  input  mem_pkg::mem_req_t          req_i,
  output logic [mem_pkg::DATA_W-1:0] rdata_o
);

  logic [mem_pkg::DATA_W-1:0] mem_q [mem_pkg::MEM_WORDS];
  logic [mem_pkg::DATA_W-1:0] rdata_q;
  logic                       wr_en;
  logic                       rd_en;

  assign wr_en = req_i.valid & req_i.we;
  assign rd_en = req_i.valid & ~req_i.we;

  // per-bit write enables, unmasked bits keep their value
  always_ff @(posedge clk_i)
  begin
    if (wr_en)
    begin
      for (int i = 0; i < mem_pkg::DATA_W; i++)
      begin
        if (req_i.wmask[i])
        begin
          mem_q[req_i.addr][i] <= req_i.wdata[i];
        end
      end
    end
  end

  // read data shows up the cycle after the request
  // and holds until the next read
  always_ff @(posedge clk_i)
  begin
    if (rd_en)
    begin
      rdata_q <= mem_q[req_i.addr];
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

//--- design/axil_mem_port.sv
// ~~~~~~~~~~~~~~~~~~~~
// AXI4-Lite slave port for the shared scratchpad
// decodes the region, builds masked memory requests, holds responses
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module axil_mem_port (
  input  logic                       clk_i,
  input  logic                       rst_i,
  input  mem_pkg::axil_req_t         axil_i,
  output mem_pkg::axil_rsp_t         axil_o,
  output mem_pkg::mem_req_t          mem_req_o,
  input  logic                       grant_i,
  input  logic [mem_pkg::DATA_W-1:0] mem_rdata_i
);

  mem_pkg::port_state_e           state_q;
  mem_pkg::mem_op_e               wr_op;
  mem_pkg::mem_op_e               rd_op;
  logic                           wr_pair;
  logic                           wr_take;
  logic                           rd_take;
  logic [mem_pkg::DATA_W-1:0]     strb_mask;
  logic [mem_pkg::DATA_W-1:0]     new_wdata;
  logic [mem_pkg::DATA_W-1:0]     new_wmask;

  // held request payload
  logic                           req_we_q;
  logic [mem_pkg::MEM_ADDR_W-1:0] addr_q;
  logic [mem_pkg::DATA_W-1:0]     wdata_q;
  logic [mem_pkg::DATA_W-1:0]     wmask_q;

  // response
  logic                           bvalid_q;
  logic                           rvalid_q;
  mem_pkg::axi_resp_e             resp_q;
  logic [mem_pkg::DATA_W-1:0]     rdata_q;

  assign wr_op = mem_pkg::mem_op_e'(axil_i.awaddr[mem_pkg::REGION_LSB +: mem_pkg::REGION_W]);
  assign rd_op = mem_pkg::mem_op_e'(axil_i.araddr[mem_pkg::REGION_LSB +: mem_pkg::REGION_W]);

  // AW and W are only taken together, writes win over reads
  assign wr_pair = axil_i.awvalid & axil_i.wvalid;
  assign wr_take = (state_q == mem_pkg::PORT_IDLE) & wr_pair;
  assign rd_take = (state_q == mem_pkg::PORT_IDLE) & ~wr_pair & axil_i.arvalid;

  always_comb
  begin
    for (int i = 0; i < mem_pkg::STRB_W; i++)
    begin
      strb_mask[8*i +: 8] = {8{axil_i.wstrb[i]}};
    end
  end

  // set and clear aliases use write data as the bit mask
  always_comb
  begin
    case (wr_op)
      mem_pkg::MEM_OP_SET:
      begin
        new_wdata = '1;
        new_wmask = axil_i.wdata;
      end
      mem_pkg::MEM_OP_CLEAR:
      begin
        new_wdata = '0;
        new_wmask = axil_i.wdata;
      end
      default:
      begin
        new_wdata = axil_i.wdata;
        new_wmask = strb_mask;
      end
    endcase
  end

  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      state_q  <= mem_pkg::PORT_IDLE;
      bvalid_q <= 1'b0;
      rvalid_q <= 1'b0;
    end
    else
    begin
      case (state_q)
        mem_pkg::PORT_IDLE:
        begin
          // bad region skips the memory and answers next cycle
          if (wr_take)
          begin
            if (wr_op == mem_pkg::MEM_OP_BAD)
            begin
              bvalid_q <= 1'b1;
              state_q  <= mem_pkg::PORT_RESP;
            end
            else
            begin
              state_q <= mem_pkg::PORT_WAIT_GRANT;
            end
          end
          else if (rd_take)
          begin
            if (rd_op == mem_pkg::MEM_OP_BAD)
            begin
              rvalid_q <= 1'b1;
              state_q  <= mem_pkg::PORT_RESP;
            end
            else
            begin
              state_q <= mem_pkg::PORT_WAIT_GRANT;
            end
          end
        end
        mem_pkg::PORT_WAIT_GRANT:
        begin
          if (grant_i)
          begin
            if (req_we_q)
            begin
              bvalid_q <= 1'b1;
              state_q  <= mem_pkg::PORT_RESP;
            end
            else
            begin
              state_q <= mem_pkg::PORT_READ_DATA;
            end
          end
        end
        mem_pkg::PORT_READ_DATA:
        begin
          rvalid_q <= 1'b1;
          state_q  <= mem_pkg::PORT_RESP;
        end
        default:
        begin
          if ((bvalid_q && axil_i.bready) || (rvalid_q && axil_i.rready))
          begin
            bvalid_q <= 1'b0;
            rvalid_q <= 1'b0;
            state_q  <= mem_pkg::PORT_IDLE;
          end
        end
      endcase
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (wr_take)
    begin
      req_we_q <= 1'b1;
      addr_q   <= axil_i.awaddr[mem_pkg::WORD_LSB +: mem_pkg::MEM_ADDR_W];
      wdata_q  <= new_wdata;
      wmask_q  <= new_wmask;
      resp_q   <= (wr_op == mem_pkg::MEM_OP_BAD) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
    end
    else if (rd_take)
    begin
      req_we_q <= 1'b0;
      addr_q   <= axil_i.araddr[mem_pkg::WORD_LSB +: mem_pkg::MEM_ADDR_W];
      resp_q   <= (rd_op == mem_pkg::MEM_OP_BAD) ? mem_pkg::RESP_SLVERR : mem_pkg::RESP_OKAY;
      rdata_q  <= '0;
    end
    // memory output is ours only the cycle after our read grant
    if (state_q == mem_pkg::PORT_READ_DATA)
    begin
      rdata_q <= mem_rdata_i;
    end
  end

  assign mem_req_o.valid = (state_q == mem_pkg::PORT_WAIT_GRANT);
  assign mem_req_o.we    = req_we_q;
  assign mem_req_o.addr  = addr_q;
  assign mem_req_o.wdata = wdata_q;
  assign mem_req_o.wmask = wmask_q;

  assign axil_o.awready = wr_take;
  assign axil_o.wready  = wr_take;
  assign axil_o.bvalid  = bvalid_q;
  assign axil_o.bresp   = resp_q;
  assign axil_o.arready = (state_q == mem_pkg::PORT_IDLE) & ~wr_pair;
  assign axil_o.rvalid  = rvalid_q;
  assign axil_o.rdata   = rdata_q;
  assign axil_o.rresp   = resp_q;

endmodule

`default_nettype wire

//--- design/mem_port_arbiter.sv
// ~~~~~~~~~~~~~~~~~~~~
// two-port round-robin arbiter
// grants one request per cycle and drives it onto the memory
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module mem_port_arbiter (
  input  logic              clk_i,
  input  logic              rst_i,
  input  mem_pkg::mem_req_t req0_i,
  input  mem_pkg::mem_req_t req1_i,
  output logic              grant0_o,
  output logic              grant1_o,
  output mem_pkg::mem_req_t mem_req_o
);

  // 0 favors port 0, 1 favors port 1
  logic              prio_q;
  logic              grant0;
  logic              grant1;

  // a lone requester always wins, a tie goes to the favored port
  assign grant0 = req0_i.valid & (~req1_i.valid | ~prio_q);
  assign grant1 = req1_i.valid & (~req0_i.valid | prio_q);

  // the port just served loses priority
  always_ff @(posedge clk_i)
  begin
    if (rst_i)
    begin
      prio_q <= 1'b0;
    end
    else if (grant0)
    begin
      prio_q <= 1'b1;
    end
    else if (grant1)
    begin
      prio_q <= 1'b0;
    end
  end

  always_comb
  begin
    if (grant0)
    begin
      mem_req_o = req0_i;
    end
    else if (grant1)
    begin
      mem_req_o = req1_i;
    end
    else
    begin
      // no requester, the memory sees an invalid request
      mem_req_o = '0;
    end
  end

  assign grant0_o = grant0;
  assign grant1_o = grant1;

endmodule

`default_nettype wire

//--- design/shared_mem_top.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared scratchpad top level
// two AXI4-Lite ports arbitrated onto one masked 1rw memory
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module shared_mem_top (
  input  logic               clk_i,
  input  logic               rst_i,
  input  mem_pkg::axil_req_t s0_axil_i,
  output mem_pkg::axil_rsp_t s0_axil_o,
  input  mem_pkg::axil_req_t s1_axil_i,
  output mem_pkg::axil_rsp_t s1_axil_o
);

  mem_pkg::mem_req_t          port0_req;
  mem_pkg::mem_req_t          port1_req;
  mem_pkg::mem_req_t          mem_req;
  logic                       grant0;
  logic                       grant1;
  logic [mem_pkg::DATA_W-1:0] mem_rdata;

  axil_mem_port port0_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axil_i      (s0_axil_i),
    .axil_o      (s0_axil_o),
    .mem_req_o   (port0_req),
    .grant_i     (grant0),
    .mem_rdata_i (mem_rdata)
  );

  axil_mem_port port1_i (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .axil_i      (s1_axil_i),
    .axil_o      (s1_axil_o),
    .mem_req_o   (port1_req),
    .grant_i     (grant1),
    .mem_rdata_i (mem_rdata)
  );

  mem_port_arbiter arb_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .req0_i    (port0_req),
    .req1_i    (port1_req),
    .grant0_o  (grant0),
    .grant1_o  (grant1),
    .mem_req_o (mem_req)
  );

  // read data fans out to both ports
  mem_1rw_sync_mask_write_bit mem_i (
    .clk_i   (clk_i),
    .req_i   (mem_req),
    .rdata_o (mem_rdata)
  );

endmodule

`default_nettype wire

//--- testbench/shared_mem_tb.sv
// ~~~~~~~~~~~~~~~~~~~~
// shared scratchpad testbench
// directed tests on both AXI4-Lite ports against a reference memory
// ~~~~~~~~~~~~~~~~~~~~
`timescale 1ns/1ps
`default_nettype none

module shared_mem_tb;

  logic                       clk_i;
  logic                       rst_i;
  mem_pkg::axil_req_t         m_req [2];
  mem_pkg::axil_rsp_t         s_rsp [2];
  logic [mem_pkg::DATA_W-1:0] ref_mem [mem_pkg::MEM_WORDS];
  int                         seed;
  int                         errors;
  int                         tests_passed;
  int                         tests_failed;
  int                         cycle_count;

  shared_mem_top dut_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .s0_axil_i (m_req[0]),
    .s0_axil_o (s_rsp[0]),
    .s1_axil_i (m_req[1]),
    .s1_axil_o (s_rsp[1])
  );

  initial
  begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // the tests need about 400 cycles, 2000 leaves a wide margin
  always @(posedge clk_i)
  begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 2000)
    begin
      $display("timeout: run passed 2000 cycles, a handshake never completed");
      $display("STATUS: FAIL");
      $finish;
    end
  end

  task automatic report_mismatch(input string what, input logic [31:0] got,
                                 input logic [31:0] exp);
    $display("CHECK FAILED at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    errors++;
  endtask

  function automatic logic [31:0] expand_strb(input logic [3:0] strb);
    logic [31:0] mask;
    for (int i = 0; i < mem_pkg::STRB_W; i++)
    begin
      mask[8*i +: 8] = strb[i] ? 8'hff : 8'h00;
    end
    return mask;
  endfunction

  // one complete handshake on port p, the response is held for hold cycles
  // lat counts cycles from the address transfer cycle to the valid response
  task automatic axi_access(input int p, input bit is_wr, input logic [11:0] addr,
                            input logic [31:0] wdata, input logic [3:0] strb, input int hold,
                            output logic [1:0] resp, output logic [31:0] rdata, output int lat);
    @(posedge clk_i);
    if (is_wr)
    begin
      m_req[p].awvalid <= 1'b1;
      m_req[p].awaddr  <= addr;
      m_req[p].wvalid  <= 1'b1;
      m_req[p].wdata   <= wdata;
      m_req[p].wstrb   <= strb;
      m_req[p].bready  <= (hold == 0);
    end
    else
    begin
      m_req[p].arvalid <= 1'b1;
      m_req[p].araddr  <= addr;
      m_req[p].rready  <= (hold == 0);
    end
    @(negedge clk_i);
    while (!(is_wr ? s_rsp[p].awready : s_rsp[p].arready))
    begin
      @(negedge clk_i);
    end
    // address and data are taken in the same cycle
    if (is_wr && !s_rsp[p].wready)
      report_mismatch("wready not raised together with awready", 32'd0, 32'd1);
    @(posedge clk_i);
    m_req[p].awvalid <= 1'b0;
    m_req[p].wvalid  <= 1'b0;
    m_req[p].arvalid <= 1'b0;
    lat = 1;
    @(negedge clk_i);
    while (!(is_wr ? s_rsp[p].bvalid : s_rsp[p].rvalid))
    begin
      @(negedge clk_i);
      lat++;
    end
    resp  = is_wr ? s_rsp[p].bresp : s_rsp[p].rresp;
    rdata = s_rsp[p].rdata;
    for (int i = 0; i < hold; i++)
    begin
      @(negedge clk_i);
      if (!(is_wr ? s_rsp[p].bvalid : s_rsp[p].rvalid))
        report_mismatch("valid dropped under back-pressure", 32'd0, 32'd1);
      if ((is_wr ? s_rsp[p].bresp : s_rsp[p].rresp) != resp)
        report_mismatch("response code changed under back-pressure",
                        32'(s_rsp[p].bresp), 32'(resp));
      if (!is_wr && s_rsp[p].rdata != rdata)
        report_mismatch("read data changed under back-pressure", s_rsp[p].rdata, rdata);
      if (s_rsp[p].arready || s_rsp[p].awready)
        report_mismatch("held port ready for a new address", 32'd1, 32'd0);
    end
    if (hold > 0)
    begin
      @(posedge clk_i);
      m_req[p].bready <= 1'b1;
      m_req[p].rready <= 1'b1;
    end
    // response transfers on this edge
    @(posedge clk_i);
    m_req[p].bready <= 1'b0;
    m_req[p].rready <= 1'b0;
  endtask

  task automatic check_response(input string what, input logic [1:0] resp, input int lat,
                                input logic [1:0] region, input int min_lat);
    logic [1:0] exp_resp;
    exp_resp = (region == 2'd3) ? 2'd2 : 2'd0;
    if (resp != exp_resp)
      report_mismatch({what, " response"}, 32'(resp), 32'(exp_resp));
    // bad region answers the cycle after acceptance
    if (region == 2'd3 && lat != 1)
      report_mismatch({what, " error latency"}, lat, 32'd1);
    if (region != 2'd3 && (lat < min_lat || lat > min_lat + 1))
    begin
      $display("CHECK FAILED at %0t ns: %s latency %0d outside %0d to %0d cycles",
               $time, what, lat, min_lat, min_lat + 1);
      errors++;
    end
  endtask

  task automatic write_word(input int p, input logic [1:0] region, input logic [7:0] word,
                            input logic [31:0] data, input logic [3:0] strb, input int hold);
    logic [1:0]  resp;
    logic [31:0] rdata;
    logic [31:0] mask;
    int          lat;
    axi_access(p, 1'b1, {region, word, 2'b00}, data, strb, hold, resp, rdata, lat);
    check_response("write", resp, lat, region, 2);
    mask = expand_strb(strb);
    case (region)
      2'd0: ref_mem[word] = (ref_mem[word] & ~mask) | (data & mask);
      2'd1: ref_mem[word] = ref_mem[word] | data;
      2'd2: ref_mem[word] = ref_mem[word] & ~data;
      default: ;
    endcase
  endtask

  task automatic read_word(input int p, input logic [1:0] region, input logic [7:0] word,
                           input int hold);
    logic [1:0]  resp;
    logic [31:0] rdata;
    int          lat;
    axi_access(p, 1'b0, {region, word, 2'b00}, 32'd0, 4'd0, hold, resp, rdata, lat);
    check_response("read", resp, lat, region, 3);
    if (region != 2'd3 && rdata !== ref_mem[word])
      report_mismatch($sformatf("read data port %0d word %0d", p, word), rdata, ref_mem[word]);
  endtask

  task automatic end_test(input string name, input int err_start);
    if (errors == err_start)
    begin
      tests_passed++;
      $display("test %s: passed", name);
    end
    else
    begin
      tests_failed++;
      $display("test %s: failed with %0d errors", name, errors - err_start);
    end
  endtask

  task automatic full_words_test();
    int err_start;
    err_start = errors;
    for (int i = 0; i < 8; i++)
    begin
      write_word(0, 2'd0, 8'(i * 37), $random(seed), 4'hf, 0);
      read_word(0, 2'd0, 8'(i * 37), 0);
      read_word(1, 2'd0, 8'(i * 37), 0);
    end
    end_test("full words", err_start);
  endtask

  task automatic partial_strobe_test();
    int err_start;
    err_start = errors;
    for (int i = 0; i < 4; i++)
    begin
      write_word(i % 2, 2'd0, 8'(i * 37), $random(seed), 4'($random(seed)), 0);
      read_word((i + 1) % 2, 2'd0, 8'(i * 37), 0);
    end
    end_test("partial strobes", err_start);
  endtask

  task automatic set_clear_test();
    int err_start;
    err_start = errors;
    for (int i = 4; i < 8; i++)
    begin
      write_word(0, 2'd1, 8'(i * 37), $random(seed), 4'hf, 0);
      read_word(1, 2'd0, 8'(i * 37), 0);
      write_word(1, 2'd2, 8'(i * 37), $random(seed), 4'hf, 0);
      read_word(0, 2'd1, 8'(i * 37), 0);
    end
    end_test("set and clear aliases", err_start);
  endtask

  task automatic dual_port_test();
    int err_start;
    err_start = errors;
    fork
      write_word(0, 2'd0, 8'd200, $random(seed), 4'hf, 0);
      write_word(1, 2'd0, 8'd201, $random(seed), 4'hf, 0);
    join
    fork
      read_word(0, 2'd0, 8'd201, 0);
      read_word(1, 2'd0, 8'd200, 0);
    join
    end_test("dual port", err_start);
  endtask

  task automatic back_pressure_test();
    int err_start;
    int hold_b;
    int hold_r;
    err_start = errors;
    hold_b = 1 + ($unsigned($random(seed)) % 8);
    hold_r = 1 + ($unsigned($random(seed)) % 8);
    fork
      begin
        write_word(0, 2'd0, 8'd20, $random(seed), 4'hf, hold_b);
        read_word(0, 2'd0, 8'd20, hold_r);
      end
      // the other port keeps going meanwhile
      for (int i = 0; i < 3; i++)
      begin
        write_word(1, 2'd0, 8'(24 + i), $random(seed), 4'hf, 0);
        read_word(1, 2'd0, 8'(24 + i), 0);
      end
    join
    end_test($sformatf("back-pressure b %0d r %0d", hold_b, hold_r), err_start);
  endtask

  task automatic bad_region_test();
    int err_start;
    err_start = errors;
    write_word(0, 2'd3, 8'd0, $random(seed), 4'hf, 0);
    read_word(1, 2'd3, 8'd0, 0);
    read_word(0, 2'd0, 8'd0, 0);
    end_test("bad region", err_start);
  endtask

  initial
  begin
    seed         = 40;
    errors       = 0;
    tests_passed = 0;
    tests_failed = 0;
    cycle_count  <= 0;
    rst_i        <= 1'b1;
    m_req[0]     <= '0;
    m_req[1]     <= '0;
    repeat (8) @(posedge clk_i);
    rst_i <= 1'b0;
    full_words_test();
    partial_strobe_test();
    set_clear_test();
    dual_port_test();
    back_pressure_test();
    bad_region_test();
    $display("tests passed %0d, tests failed %0d, check errors %0d",
             tests_passed, tests_failed, errors);
    if (errors == 0 && tests_failed == 0)
    begin
      $display("STATUS: PASS");
    end
    else
    begin
      $display("STATUS: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog.f
design/mem_pkg.sv
design/mem_1rw_sync_mask_write_bit.sv
design/axil_mem_port.sv
design/mem_port_arbiter.sv
design/shared_mem_top.sv
testbench/shared_mem_tb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the shared scratchpad testbench with Verilator
set -e

cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing -f verilog.f --top-module shared_mem_tb -o shared_mem_sim

./obj_dir/shared_mem_sim | tee sim.log

if grep -qx "STATUS: PASS" sim.log; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see sim.log"
  exit 1
fi
